//--- compile.f
+incdir+include
hw/cpu85_isa_pkg.sv
hw/bus_cycle_pkg.sv
hw/cycle_sequencer.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu8.sv
hw/bus_unit.sv
hw/cpu85_top.sv
tb/tb_bus_memory.sv
tb/tb_cpu85.sv

//--- run_sim.sh
#!/bin/sh
# build the cpu85 testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f compile.f \
	--top-module tb_cpu85 -o sim_cpu85 > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_cpu85 > sim.log 2>&1
grep -q "Done: errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }

//--- tb/tb_cpu85.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu85_cfg.svh"

module tb_cpu85;
	import cpu85_isa_pkg::*;
	import bus_cycle_pkg::*;

	localparam int NUM_INSTR = 200;
	localparam int RESET_CYCLES = 16;
	localparam int CLK_NS = 10;
	// twice 3 machine cycles of up to 3 + 4 clocks per instruction
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_INSTR * 3 * (3 + 4) * 2) * CLK_NS;

	logic                      clk = 1'b0;
	logic                      rst = 1'b1;
	logic [`CPU85_DATA_W-1:0]  din;
	logic                      ready;
	logic [`CPU85_ADDR_W-1:0]  addr;
	logic                      ale;
	logic [`CPU85_DATA_W-1:0]  dout;
	logic                      rd_n;
	logic                      wr_n;
	logic                      iom_n;
	logic                      s1;
	logic                      s0;
	logic                      halt;
	logic [1:0]                wait_cycles = 2'd0;
	logic                      wr_done;
	logic [`CPU85_ADDR_W-1:0]  wr_addr;
	logic [`CPU85_DATA_W-1:0]  wr_data;

	logic [31:0]               rng = 32'd71829;
	logic [`CPU85_ADDR_W-1:0]  code_ptr;
	logic [7:0]                model_mem [0:(1 << `CPU85_ADDR_W) - 1];
	logic [7:0]                m_regs [0:7]; // slot 6 unused
	logic                      m_cy;
	mcycle_t                   exp_kind [$];
	logic [`CPU85_ADDR_W-1:0]  exp_addr [$];
	logic [`CPU85_ADDR_W-1:0]  exp_waddr [$];
	logic [`CPU85_DATA_W-1:0]  exp_wdata [$];

	// bus monitor state for the current machine cycle
	logic                      in_cycle = 1'b0;
	mcycle_t                   cyc_kind;
	logic [`CPU85_ADDR_W-1:0]  cyc_addr;
	logic [`CPU85_DATA_W-1:0]  cyc_data;
	logic [2:0]                cyc_pins;
	logic [1:0]                cyc_waits; // wait states the memory picked in T1
	int                        strobe_cnt;
	logic                      strobe_done;

	cpu85_top UUT (
		.clk     (clk),
		.rst     (rst),
		.i_din   (din),
		.i_ready (ready),
		.o_addr  (addr),
		.o_ale   (ale),
		.o_dout  (dout),
		.o_rd_n  (rd_n),
		.o_wr_n  (wr_n),
		.o_iom_n (iom_n),
		.o_s1    (s1),
		.o_s0    (s0),
		.o_halt  (halt)
	);

	tb_bus_memory u_mem (
		.clk       (clk),
		.i_addr    (addr),
		.i_ale     (ale),
		.i_rd_n    (rd_n),
		.i_wr_n    (wr_n),
		.i_dout    (dout),
		.i_wait    (wait_cycles),
		.o_din     (din),
		.o_ready   (ready),
		.o_wr_done (wr_done),
		.o_wr_addr (wr_addr),
		.o_wr_data (wr_data)
	);

	initial begin
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h5a;
	endfunction

	// {iom_n, s1, s0} of each cycle kind
	function automatic logic [2:0] status_pins(input mcycle_t kind);
		stat_ctl_t s;
		case (kind)
			OPFETCH: s = CYC_OF;
			MEMREAD: s = CYC_MR;
			MEMWRITE: s = CYC_MW;
			default: s = CYC_HALT;
		endcase
		return {s[SC_IOM_N], s[SC_S1], s[SC_S0]};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_eq(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected)
			abort_run($sformatf("[ERROR] %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic emit_byte(input logic [7:0] v);
		u_mem.mem[code_ptr] = v;
		model_mem[code_ptr] = v;
		code_ptr = code_ptr + 16'd1;
	endtask

	task automatic build_program();
		logic [2:0] f1;
		logic [2:0] f2;
		logic [7:0] imm;
		for (int a = 0; a < (1 << `CPU85_ADDR_W); a++) begin
			u_mem.mem[a] = fill_byte(16'(a));
			model_mem[a] = fill_byte(16'(a));
		end
		code_ptr = `CPU85_RESET_PC;
		rng = xorshift32(rng);
		emit_byte(8'h26); // MVI H puts HL in the data area
		emit_byte(rng[7:0] | 8'h80);
		for (int i = 1; i < NUM_INSTR - 1; i++) begin
			rng = xorshift32(rng);
			f1 = rng[5:3];
			f2 = rng[8:6];
			imm = rng[23:16];
			case (rng[2:0])
				3'd0: emit_byte(8'h00);
				3'd1, 3'd2: begin
					if (f1 == REG_H)
						f1 = REG_A; // H only changes through MVI
					if (f1 == REG_M && f2 == REG_M)
						f2 = REG_A; // that code is HLT
					emit_byte({2'b01, f1, f2});
				end
				3'd3: begin
					emit_byte({2'b00, f1, 3'b110});
					emit_byte((f1 == REG_H) ? (imm | 8'h80) : imm);
				end
				3'd4, 3'd5: emit_byte({2'b10, f1, f2});
				default: begin
					emit_byte({2'b11, f1, 3'b110});
					emit_byte(imm);
				end
			endcase
		end
		emit_byte(8'h76);
	endtask

	task automatic expect_cycle(input mcycle_t kind, input logic [15:0] a);
		exp_kind.push_back(kind);
		exp_addr.push_back(a);
	endtask

	task automatic model_read(input logic [15:0] a, output logic [7:0] v);
		expect_cycle(MEMREAD, a);
		v = model_mem[a];
	endtask

	task automatic model_store(input logic [2:0] dst, input logic [7:0] v);
		logic [15:0] hl;
		hl = {m_regs[REG_H], m_regs[REG_L]};
		if (dst == REG_M) begin
			expect_cycle(MEMWRITE, hl);
			exp_waddr.push_back(hl);
			exp_wdata.push_back(v);
			model_mem[hl] = v;
		end else begin
			m_regs[dst] = v;
		end
	endtask

	task automatic model_alu(input logic [2:0] op, input logic [7:0] b);
		logic [8:0] t;
		logic       ci;
		ci = (alu_op_t'(op) == ADC || alu_op_t'(op) == SBB) ? m_cy : 1'b0;
		case (alu_op_t'(op))
			ADD, ADC: t = {1'b0, m_regs[REG_A]} + {1'b0, b} + {8'd0, ci};
			SUB, SBB, CMP: t = {1'b0, m_regs[REG_A]} - {1'b0, b} - {8'd0, ci}; // bit 8 is borrow
			ANA: t = {1'b0, m_regs[REG_A] & b};
			XRA: t = {1'b0, m_regs[REG_A] ^ b};
			default: t = {1'b0, m_regs[REG_A] | b};
		endcase
		m_cy = t[8];
		if (alu_op_t'(op) != CMP)
			m_regs[REG_A] = t[7:0];
	endtask

	// walks the program and queues every bus cycle and write it should make
	task automatic run_model();
		logic [15:0] pc;
		logic [7:0]  op;
		logic [7:0]  v;
		logic        done;
		for (int r = 0; r < 8; r++)
			m_regs[r] = 8'h00;
		m_cy = 1'b0;
		pc = `CPU85_RESET_PC;
		done = 1'b0;
		while (!done) begin
			op = model_mem[pc];
			expect_cycle(OPFETCH, pc);
			pc = pc + 16'd1;
			if (op == 8'h76) begin
				done = 1'b1;
			end else if (op[7:6] == 2'b01) begin
				if (op[2:0] == REG_M)
					model_read({m_regs[REG_H], m_regs[REG_L]}, v);
				else
					v = m_regs[op[2:0]];
				model_store(op[5:3], v);
			end else if (op[7:6] == 2'b00) begin
				if (op[2:0] == 3'b110) begin // MVI when the low bits are 110
					model_read(pc, v);
					pc = pc + 16'd1;
					model_store(op[5:3], v);
				end
			end else if (op[7:6] == 2'b10) begin
				if (op[2:0] == REG_M)
					model_read({m_regs[REG_H], m_regs[REG_L]}, v);
				else
					v = m_regs[op[2:0]];
				model_alu(op[5:3], v);
			end else begin
				model_read(pc, v);
				pc = pc + 16'd1;
				model_alu(op[5:3], v);
			end
		end
	endtask

	task automatic start_cycle();
		check_eq(rd_n, 1'b1, "rd_n low in T1");
		check_eq(wr_n, 1'b1, "wr_n low in T1");
		if (exp_kind.size() == 0)
			abort_run("a bus cycle started after the last one the model predicts");
		cyc_kind = exp_kind.pop_front();
		cyc_addr = exp_addr.pop_front();
		cyc_pins = status_pins(cyc_kind);
		check_eq({iom_n, s1, s0}, cyc_pins, "status in T1");
		check_eq(addr, cyc_addr, "address in T1");
		cyc_waits = wait_cycles;
		strobe_cnt = 0;
		strobe_done = 1'b0;
		in_cycle = 1'b1;
	endtask

	task automatic track_strobe();
		logic act;
		logic idle;
		act = (cyc_kind == MEMWRITE) ? wr_n : rd_n;
		idle = (cyc_kind == MEMWRITE) ? rd_n : wr_n;
		check_eq(idle, 1'b1, "wrong strobe active");
		check_eq({iom_n, s1, s0}, cyc_pins, "status held in cycle");
		if (!act) begin
			check_eq(strobe_done, 1'b0, "strobe fell twice in one cycle");
			check_eq(addr, cyc_addr, "address held under strobe");
			if (strobe_cnt == 0)
				cyc_data = dout;
			if (cyc_kind == MEMWRITE)
				check_eq(dout, cyc_data, "write data held under strobe");
			strobe_cnt++;
		end else if (strobe_cnt != 0) begin
			strobe_done = 1'b1;
		end
	endtask

	// bus monitor sampling where the core's outputs are settled
	always @(negedge clk) begin
		if (rst) begin
			check_eq(rd_n, 1'b1, "rd_n in reset");
			check_eq(wr_n, 1'b1, "wr_n in reset");
			check_eq(ale, 1'b0, "ale in reset");
			check_eq(iom_n, 1'b1, "iom_n in reset");
			check_eq(halt, 1'b0, "halt in reset");
		end else if (halt || ale) begin
			if (in_cycle) // T2 and T3 plus one TW per wait state
				check_eq(16'(strobe_cnt), 16'(cyc_waits) + 16'd2,
					"strobe length over T2, wait states and T3");
			in_cycle = 1'b0;
			if (halt) begin
				check_eq({iom_n, s1, s0}, status_pins(HALT), "status while halted");
				check_eq({ale, rd_n, wr_n}, 3'b011, "strobes while halted");
			end else begin
				start_cycle();
			end
		end else if (in_cycle) begin
			track_strobe();
		end
		if (wr_done) begin
			if (exp_waddr.size() == 0)
				abort_run("memory reported a write that the model does not predict");
			check_eq(wr_addr, exp_waddr.pop_front(), "write address");
			check_eq(wr_data, exp_wdata.pop_front(), "write data");
		end
	end

	always @(negedge clk) begin
		rng = xorshift32(rng);
		wait_cycles <= rng[1:0];
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("timeout, the core did not halt in time");
	end

	initial begin
		build_program();
		run_model();
		repeat (RESET_CYCLES) @(negedge clk);
		rst <= 1'b0;
		while (!halt)
			@(negedge clk);
		repeat (8) @(negedge clk); // halt pins are watched by the monitor
		check_eq(exp_kind.size() == 0, 1'b1, "all predicted bus cycles seen");
		check_eq(exp_waddr.size() == 0, 1'b1, "all predicted writes seen");
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_bus_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu85_cfg.svh"

module tb_bus_memory (
	input  wire                       clk,
	input  wire [`CPU85_ADDR_W-1:0]   i_addr,
	input  wire                       i_ale,
	input  wire                       i_rd_n,
	input  wire                       i_wr_n,
	input  wire [`CPU85_DATA_W-1:0]   i_dout,
	input  wire [1:0]                 i_wait,    // wait states for the next cycle
	output logic [`CPU85_DATA_W-1:0]  o_din,
	output logic                      o_ready,
	output logic                      o_wr_done, // one pulse per write cycle
	output logic [`CPU85_ADDR_W-1:0]  o_wr_addr,
	output logic [`CPU85_DATA_W-1:0]  o_wr_data
);
	logic [`CPU85_DATA_W-1:0] mem [0:(1 << `CPU85_ADDR_W) - 1];
	logic [`CPU85_DATA_W-1:0] din_q = '0;
	logic                     ready_q = 1'b1;
	logic                     done_q = 1'b0;
	logic [`CPU85_ADDR_W-1:0] waddr_q = '0;
	logic [`CPU85_DATA_W-1:0] wdata_q = '0;
	logic [1:0]               wait_left = 2'd0;
	logic                     wr_seen = 1'b0;

	// everything moves on the falling edge, the core samples on the rising one
	always @(negedge clk) begin
		done_q <= 1'b0;
		if (i_ale) begin
			wait_left <= i_wait; // count picked in T1
			wr_seen <= 1'b0;
		end else if (!i_rd_n || !i_wr_n) begin
			ready_q <= (wait_left == 2'd0);
			if (wait_left != 2'd0)
				wait_left <= wait_left - 2'd1;
			if (!i_rd_n)
				din_q <= mem[i_addr];
			if (!i_wr_n && !wr_seen) begin
				mem[i_addr] = i_dout; // data is valid from T2
				wr_seen <= 1'b1;
				done_q <= 1'b1;
				waddr_q <= i_addr;
				wdata_q <= i_dout;
			end
		end
	end

	assign o_din = din_q;
	assign o_ready = ready_q;
	assign o_wr_done = done_q;
	assign o_wr_addr = waddr_q;
	assign o_wr_data = wdata_q;

endmodule

`default_nettype wire

//--- hw/cpu85_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu85_cfg.svh"

module cpu85_top (
	input  wire                      clk,
	input  wire                      rst,
	input  wire [`CPU85_DATA_W-1:0]  i_din,
	input  wire                      i_ready,
	output wire [`CPU85_ADDR_W-1:0]  o_addr,
	output wire                      o_ale,
	output wire [`CPU85_DATA_W-1:0]  o_dout,
	output wire                      o_rd_n,
	output wire                      o_wr_n,
	output wire                      o_iom_n,
	output wire                      o_s1,
	output wire                      o_s0,
	output wire                      o_halt
);
	import cpu85_isa_pkg::*;
	import bus_cycle_pkg::*;

	t_state_t                  t_state;
	mcycle_t                   cycle;
	logic                      ir_load;
	logic                      opnd_load;
	logic                      exec;
	logic                      pc_inc;
	instr_class_t              cls;
	reg_idx_t                  dst;
	reg_idx_t                  src;
	alu_op_t                   alu_op;
	logic [1:0]                cycles;
	logic                      wr_last;
	logic                      is_hlt;
	logic                      mem_src;
	logic [`CPU85_DATA_W-1:0]  acc;
	logic [`CPU85_DATA_W-1:0]  src_val;
	logic [`CPU85_DATA_W-1:0]  store_val;
	logic [`CPU85_DATA_W-1:0]  alu_res;
	logic [`CPU85_ADDR_W-1:0]  hl;
	flags_t                    flags;
	flags_t                    alu_flags;

	cycle_sequencer u_seq (
		.clk         (clk),
		.rst         (rst),
		.i_ready     (i_ready),
		.i_cycles    (cycles),
		.i_wr_last   (wr_last),
		.i_is_hlt    (is_hlt),
		.o_t_state   (t_state),
		.o_cycle     (cycle),
		.o_ir_load   (ir_load),
		.o_opnd_load (opnd_load),
		.o_exec      (exec),
		.o_pc_inc    (pc_inc)
	);

	instr_decoder u_dec (
		.clk       (clk),
		.rst       (rst),
		.i_ir_load (ir_load),
		.i_din     (i_din),
		.o_class   (cls),
		.o_dst     (dst),
		.o_src     (src),
		.o_alu_op  (alu_op),
		.o_cycles  (cycles),
		.o_wr_last (wr_last),
		.o_is_hlt  (is_hlt),
		.o_mem_src (mem_src)
	);

	reg_file u_regs (
		.clk         (clk),
		.rst         (rst),
		.i_exec      (exec),
		.i_opnd_load (opnd_load),
		.i_din       (i_din),
		.i_class     (cls),
		.i_dst       (dst),
		.i_src       (src),
		.i_mem_src   (mem_src),
		.i_alu_res   (alu_res),
		.i_alu_flags (alu_flags),
		.o_acc       (acc),
		.o_src_val   (src_val),
		.o_hl        (hl),
		.o_flags     (flags),
		.o_store_val (store_val)
	);

	alu8 u_alu (
		.i_op    (alu_op),
		.i_a     (acc),
		.i_b     (src_val),
		.i_cy    (flags[FLAG_CY]),
		.o_res   (alu_res),
		.o_flags (alu_flags)
	);

	bus_unit u_bus (
		.clk         (clk),
		.rst         (rst),
		.i_t_state   (t_state),
		.i_cycle     (cycle),
		.i_pc_inc    (pc_inc),
		.i_hl        (hl),
		.i_store_val (store_val),
		.i_mem_src   (mem_src),
		.o_addr      (o_addr),
		.o_ale       (o_ale),
		.o_dout      (o_dout),
		.o_rd_n      (o_rd_n),
		.o_wr_n      (o_wr_n),
		.o_iom_n     (o_iom_n),
		.o_s1        (o_s1),
		.o_s0        (o_s0),
		.o_halt      (o_halt)
	);

endmodule

`default_nettype wire

//--- hw/bus_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu85_cfg.svh"

module bus_unit (
	input  wire                       clk,
	input  wire                       rst,
	input  bus_cycle_pkg::t_state_t   i_t_state,
	input  bus_cycle_pkg::mcycle_t    i_cycle,
	input  wire                       i_pc_inc,
	input  wire [`CPU85_ADDR_W-1:0]   i_hl,
	input  wire [`CPU85_DATA_W-1:0]   i_store_val,
	input  wire                       i_mem_src,
	output logic [`CPU85_ADDR_W-1:0]  o_addr,
	output logic                      o_ale,
	output logic [`CPU85_DATA_W-1:0]  o_dout,
	output logic                      o_rd_n,
	output logic                      o_wr_n,
	output logic                      o_iom_n,
	output logic                      o_s1,
	output logic                      o_s0,
	output logic                      o_halt
);
	import bus_cycle_pkg::*;

	logic [`CPU85_ADDR_W-1:0] pc;
	logic [`CPU85_DATA_W-1:0] dout_q;
	logic                     hl_cycle; // data cycle addressed by HL
	logic                     strobe;   // rd/wr window
	stat_ctl_t                stat;

	assign hl_cycle = (i_cycle == MEMWRITE) || ((i_cycle == MEMREAD) && i_mem_src);

	// immediates advance the PC, HL reads do not
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= `CPU85_RESET_PC;
		else if (i_pc_inc && !hl_cycle)
			pc <= pc + 1'b1;
	end

	// write data latched in T1, valid on the pins from T2
	always_ff @(posedge clk) begin
		if (i_t_state == T1)
			dout_q <= i_store_val;
	end

	always_comb begin
		case (i_cycle)
			OPFETCH: stat = CYC_OF;
			MEMREAD: stat = CYC_MR;
			MEMWRITE: stat = CYC_MW;
			default: stat = CYC_HALT;
		endcase
		if (i_t_state == TR)
			stat = CYC_HALT; // pins idle before the first T1
	end

	assign strobe = (i_t_state == T2) || (i_t_state == TW) || (i_t_state == T3);

	assign o_addr = hl_cycle ? i_hl : pc;
	assign o_ale = (i_t_state == T1);
	assign o_dout = dout_q;
	assign o_rd_n = stat[SC_RD_N] | ~strobe;
	assign o_wr_n = stat[SC_WR_N] | ~strobe;
	assign o_iom_n = stat[SC_IOM_N];
	assign o_s1 = stat[SC_S1];
	assign o_s0 = stat[SC_S0];
	assign o_halt = (i_t_state == TT);

endmodule

`default_nettype wire

//--- hw/alu8.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu85_cfg.svh"

module alu8 (
	input  cpu85_isa_pkg::alu_op_t    i_op,
	input  wire [`CPU85_DATA_W-1:0]   i_a,
	input  wire [`CPU85_DATA_W-1:0]   i_b,
	input  wire                       i_cy,
	output logic [`CPU85_DATA_W-1:0]  o_res,
	output cpu85_isa_pkg::flags_t     o_flags
);
	import cpu85_isa_pkg::*;

	logic                     is_sub;
	logic                     use_cy;
	logic                     c0;
	logic [`CPU85_DATA_W-1:0] b_op;
	logic [`CPU85_DATA_W:0]   sum;
	logic [4:0]               nib;   // low nibble add for AC
	logic                     cy;
	logic                     ac;
	flags_t                   fl;

	assign is_sub = (i_op == SUB) || (i_op == SBB) || (i_op == CMP);
	assign use_cy = (i_op == ADC) || (i_op == SBB);
	assign b_op = is_sub ? ~i_b : i_b; // subtract by adding the complement
	assign c0 = is_sub ? ~(use_cy & i_cy) : (use_cy & i_cy);
	assign sum = {1'b0, i_a} + {1'b0, b_op} + {{`CPU85_DATA_W{1'b0}}, c0};
	assign nib = {1'b0, i_a[3:0]} + {1'b0, b_op[3:0]} + {4'b0000, c0};

	always_comb begin
		case (i_op)
			ANA: begin
				o_res = i_a & i_b;
				cy = 1'b0;
				ac = i_a[3] | i_b[3]; // 8085 behaviour
			end
			XRA: begin
				o_res = i_a ^ i_b;
				cy = 1'b0;
				ac = 1'b0;
			end
			ORA: begin
				o_res = i_a | i_b;
				cy = 1'b0;
				ac = 1'b0;
			end
			default: begin
				o_res = sum[`CPU85_DATA_W-1:0];
				cy = sum[`CPU85_DATA_W] ^ is_sub; // borrow on subtract
				ac = nib[4];
			end
		endcase
	end

	always_comb begin
		fl = '0;
		fl[FLAG_S] = o_res[`CPU85_DATA_W-1];
		fl[FLAG_Z] = (o_res == '0);
		fl[FLAG_AC] = ac;
		fl[FLAG_P] = ~^o_res; // even parity
		fl[FLAG_CY] = cy;
	end

	assign o_flags = fl & FLAG_MASK;

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu85_cfg.svh"

module reg_file (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          i_exec,
	input  wire                          i_opnd_load,
	input  wire [`CPU85_DATA_W-1:0]      i_din,
	input  cpu85_isa_pkg::instr_class_t  i_class,
	input  cpu85_isa_pkg::reg_idx_t      i_dst,
	input  cpu85_isa_pkg::reg_idx_t      i_src,
	input  wire                          i_mem_src,
	input  wire [`CPU85_DATA_W-1:0]      i_alu_res,
	input  cpu85_isa_pkg::flags_t        i_alu_flags,
	output logic [`CPU85_DATA_W-1:0]     o_acc,
	output logic [`CPU85_DATA_W-1:0]     o_src_val,
	output logic [`CPU85_ADDR_W-1:0]     o_hl,
	output cpu85_isa_pkg::flags_t        o_flags,
	output logic [`CPU85_DATA_W-1:0]     o_store_val
);
	import cpu85_isa_pkg::*;

	logic [`CPU85_DATA_W-1:0] regs [`CPU85_NUM_REGS]; // slot M holds the memory operand
	flags_t                   flags;
	logic                     from_bus;
	logic                     is_load;
	logic                     is_alu;
	logic                     is_cmp;

	assign from_bus = i_mem_src || (i_class == MVI) || (i_class == ALU_IMM);
	assign is_load = ((i_class == MOV) || (i_class == MVI)) && (i_dst != REG_M);
	assign is_alu = (i_class == ALU_REG) || (i_class == ALU_IMM);
	assign is_cmp = (alu_op_t'(i_dst) == CMP); // alu op sits in the dst field

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `CPU85_NUM_REGS; i++)
				regs[i] <= '0;
			flags <= '0;
		end else begin
			if (i_opnd_load)
				regs[REG_M] <= i_din;
			if (i_exec) begin
				if (is_load)
					regs[i_dst] <= o_src_val;
				if (is_alu) begin
					flags <= i_alu_flags;
					if (!is_cmp)
						regs[REG_A] <= i_alu_res; // CMP keeps A
				end
			end
		end
	end

	assign o_acc = regs[REG_A];
	assign o_src_val = from_bus ? i_din : regs[i_src]; // bus data used in its own T3
	assign o_hl = {regs[REG_H], regs[REG_L]};
	assign o_flags = flags;
	// MVI M has src code 6 so it stores the operand temp
	assign o_store_val = regs[i_src];

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu85_cfg.svh"

module instr_decoder (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          i_ir_load,
	input  wire [`CPU85_DATA_W-1:0]      i_din,
	output cpu85_isa_pkg::instr_class_t  o_class,
	output cpu85_isa_pkg::reg_idx_t      o_dst,
	output cpu85_isa_pkg::reg_idx_t      o_src,
	output cpu85_isa_pkg::alu_op_t       o_alu_op,
	output logic [1:0]                   o_cycles,  // cycles after the fetch
	output logic                         o_wr_last,
	output logic                         o_is_hlt,
	output logic                         o_mem_src
);
	import cpu85_isa_pkg::*;

	logic [`CPU85_DATA_W-1:0] ir;
	logic                     dst_m;
	logic                     src_m;
	logic                     low_110; // immediate forms end in 110

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ir <= '0; // decodes as NOP
		else if (i_ir_load)
			ir <= i_din;
	end

	assign o_dst = ir[5:3];
	assign o_src = ir[2:0];
	assign o_alu_op = alu_op_t'(ir[5:3]);
	assign dst_m = (o_dst == REG_M);
	assign src_m = (o_src == REG_M);
	assign low_110 = (ir[2:0] == 3'b110);

	// top two bits pick the group
	always_comb begin
		case (ir[7:6])
			2'b00: o_class = low_110 ? MVI : NOP; // rest of group unsupported
			2'b01: o_class = (dst_m && src_m) ? HLT : MOV;
			2'b10: o_class = ALU_REG;
			default: o_class = low_110 ? ALU_IMM : NOP;
		endcase
	end

	always_comb begin
		o_cycles = 2'd0;
		o_wr_last = 1'b0;
		o_mem_src = 1'b0;
		case (o_class)
			MOV: begin
				o_cycles = (dst_m || src_m) ? 2'd1 : 2'd0;
				o_wr_last = dst_m;
				o_mem_src = src_m;
			end
			MVI: begin
				o_cycles = dst_m ? 2'd2 : 2'd1; // operand read, then store
				o_wr_last = dst_m;
			end
			ALU_REG: begin
				o_cycles = {1'b0, src_m};
				o_mem_src = src_m;
			end
			ALU_IMM: o_cycles = 2'd1;
			default: o_cycles = 2'd0;
		endcase
	end

	assign o_is_hlt = (o_class == HLT);

endmodule

`default_nettype wire

//--- hw/cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     i_ready,
	input  wire [1:0]               i_cycles,  // machine cycles after the fetch
	input  wire                     i_wr_last,
	input  wire                     i_is_hlt,
	output bus_cycle_pkg::t_state_t o_t_state,
	output bus_cycle_pkg::mcycle_t  o_cycle,
	output logic                    o_ir_load,
	output logic                    o_opnd_load,
	output logic                    o_exec,
	output logic                    o_pc_inc
);
	import bus_cycle_pkg::*;

	t_state_t   state;
	t_state_t   state_nx;
	mcycle_t    cyc;
	mcycle_t    cyc_nx;
	logic [1:0] remain;    // cycles left, current one included
	logic [1:0] remain_nx;

	// kind of the next machine cycle given how many are left
	function automatic mcycle_t kind_for(input logic [1:0] left, input logic wr_last);
		if (left == 2'd0)
			return OPFETCH;
		if (left == 2'd1 && wr_last)
			return MEMWRITE; // only the last cycle can write
		return MEMREAD;
	endfunction

	always_comb begin
		state_nx = state;
		cyc_nx = cyc;
		remain_nx = remain;
		case (state)
			TR: state_nx = T1;
			T1: state_nx = T2;
			T2, TW: state_nx = i_ready ? T3 : TW; // wait while not ready
			T3: begin
				if (cyc == OPFETCH) begin
					state_nx = T4;
				end else begin
					state_nx = T1;
					remain_nx = remain - 2'd1;
					cyc_nx = kind_for(remain_nx, i_wr_last);
				end
			end
			T4: begin
				if (i_is_hlt) begin
					state_nx = TT;
					cyc_nx = HALT;
				end else begin
					state_nx = T1;
					remain_nx = i_cycles; // plan of the new instruction
					cyc_nx = kind_for(i_cycles, i_wr_last);
				end
			end
			default: state_nx = TT; // halted until reset
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= TR;
			cyc <= OPFETCH;
			remain <= 2'd0;
		end else begin
			state <= state_nx;
			cyc <= cyc_nx;
			remain <= remain_nx;
		end
	end

	assign o_t_state = state;
	assign o_cycle = cyc;
	assign o_ir_load = (state == T3) && (cyc == OPFETCH);
	assign o_opnd_load = (state == T3) && (cyc == MEMREAD);
	// single cycle ops run in T4, the rest on their last read
	assign o_exec = ((state == T4) && (i_cycles == 2'd0)) ||
		((state == T3) && (cyc == MEMREAD) && (remain == 2'd1));
	assign o_pc_inc = (state == T3) && ((cyc == OPFETCH) || (cyc == MEMREAD));

endmodule

`default_nettype wire

//--- hw/bus_cycle_pkg.sv
`default_nettype none

package bus_cycle_pkg;

	// TT is the halt state
	typedef enum logic [2:0] {
		TR, T1, T2, TW, T3, T4, TT
	} t_state_t;

	typedef enum logic [1:0] {
		OPFETCH, MEMREAD, MEMWRITE, HALT
	} mcycle_t;

	// {inta_n, wr_n, rd_n, iom_n, s1, s0}
	typedef logic [5:0] stat_ctl_t;

	localparam int SC_S0    = 0;
	localparam int SC_S1    = 1;
	localparam int SC_IOM_N = 2;
	localparam int SC_RD_N  = 3;
	localparam int SC_WR_N  = 4;

	localparam stat_ctl_t CYC_OF   = 6'b110011; // opcode fetch
	localparam stat_ctl_t CYC_MR   = 6'b110010; // memory read
	localparam stat_ctl_t CYC_MW   = 6'b101001; // memory write
	localparam stat_ctl_t CYC_HALT = 6'b111100; // halt, also idle pins

endpackage

`default_nettype wire

//--- hw/cpu85_isa_pkg.sv
`default_nettype none

package cpu85_isa_pkg;

	// same order as opcode bits 5..3
	typedef enum logic [2:0] {
		ADD, ADC, SUB, SBB, ANA, XRA, ORA, CMP
	} alu_op_t;

	typedef logic [2:0] reg_idx_t;

	localparam reg_idx_t REG_H = 3'd4;
	localparam reg_idx_t REG_L = 3'd5;
	localparam reg_idx_t REG_M = 3'd6; // memory through HL
	localparam reg_idx_t REG_A = 3'd7;

	typedef enum logic [2:0] {
		NOP, HLT, MOV, MVI, ALU_REG, ALU_IMM
	} instr_class_t;

	typedef logic [7:0] flags_t;

	localparam int FLAG_S  = 7;
	localparam int FLAG_Z  = 6;
	localparam int FLAG_AC = 4;
	localparam int FLAG_P  = 2;
	localparam int FLAG_CY = 0;

	localparam flags_t FLAG_MASK = 8'b11010101;

endpackage

`default_nettype wire

//--- include/cpu85_cfg.svh
`ifndef CPU85_CFG_SVH
`define CPU85_CFG_SVH

`define CPU85_DATA_W   8        // data bus and register width
`define CPU85_ADDR_W   16       // address bus width
`define CPU85_RESET_PC 16'h0000 // first fetch after reset

// register slots, code 6 is M and code 7 is A
`define CPU85_NUM_REGS 8

`endif
